// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tbRiscvCore
FILELIST  := vlog.f
PASS_MSG  := Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== verif/riscvCore_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module riscvCoreSva #(
    parameter int addrWidth = 16
) (
    input logic                 cpuSignals,
    input logic                 arstN,
    input logic [addrWidth-1:0] address,
    input logic [7:0]           dataWrite,
    input logic                 writeEnable,
    input logic                 strobe,
    input logic                 ready
);

    // Request held until the memory answers
    stableWhileWaiting: assert property (@(posedge cpuSignals) disable iff (!arstN)
        strobe && !ready |=> $stable(address) && $stable(writeEnable))
        else $error("address or writeEnable changed while waiting for ready");

    // Write data only matters on writes
    dataStableWhileWaiting: assert property (@(posedge cpuSignals) disable iff (!arstN)
        strobe && writeEnable && !ready |=> $stable(dataWrite))
        else $error("dataWrite changed while waiting for ready");

    strobeDropsAfterReady: assert property (@(posedge cpuSignals) disable iff (!arstN)
        strobe && ready |=> !strobe)
        else $error("strobe still high in the cycle after ready");

    // Sixteen registers of four bytes
    writeInRegArea: assert property (@(posedge cpuSignals) disable iff (!arstN)
        strobe && writeEnable |-> address < 64)
        else $error("write outside the register area");

endmodule

bind riscvCore riscvCoreSva #(.addrWidth(addrWidth)) uSva (
    .cpuSignals(cpuSignals),
    .arstN(arstN),
    .address(address),
    .dataWrite(dataWrite),
    .writeEnable(writeEnable),
    .strobe(strobe),
    .ready(ready)
);

`default_nettype wire

// ==== verif/tbRiscvCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbRiscvCore;

    localparam int numInsns = 200;
    localparam int timeoutCycles = numInsns * 200;
    localparam logic [15:0] progBase = 16'h2000;

    logic cpuSignals = 1'b0;
    logic arstN;
    logic [15:0] address;
    logic [7:0] dataWrite;
    logic [7:0] dataRead;
    logic writeEnable;
    logic strobe;
    logic ready;

    logic [7:0] mem [0:65535];
    logic [31:0] regs [0:15];
    logic [31:0] lfsr = 32'hf37e;
    // Expected access as {writeEnable, address, data}
    logic [24:0] expQ [$];
    logic [24:0] expNow;
    logic busy;
    logic [1:0] waitLeft;
    int waitNow;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int nLui = 0;
    int nImm = 0;
    int nOp = 0;
    int nNop = 0;

    riscvCore #(.addrWidth(16), .resetPc(16'h2000)) u_dut (
        .cpuSignals(cpuSignals),
        .arstN(arstN),
        .address(address),
        .dataWrite(dataWrite),
        .dataRead(dataRead),
        .writeEnable(writeEnable),
        .strobe(strobe),
        .ready(ready)
    );

    always #4 cpuSignals = ~cpuSignals;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd4: return a ^ b;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic expectWord(input logic we, input logic [3:0] r, input logic [31:0] d);
        for (int k = 0; k < 4; k++) begin
            expQ.push_back({we, 10'd0, r, 2'(k), d[8*k +: 8]});
        end
    endtask

    // Random instruction, mostly kept ops, some shift, SLT and branch encodings
    function automatic logic [31:0] makeInsn();
        logic [3:0] kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [2:0] sel;
        logic [2:0] keptF3 [4];
        logic [2:0] dropF3 [4];
        keptF3 = '{3'd0, 3'd4, 3'd6, 3'd7};
        dropF3 = '{3'd1, 3'd2, 3'd3, 3'd5};
        kind = 4'(randBits(4));
        rd = {1'b0, 4'(randBits(4))};
        rs1 = {1'b0, 4'(randBits(4))};
        rs2 = {1'b0, 4'(randBits(4))};
        if (kind < 5) begin
            return {20'(randBits(20)), rd, 7'b0110111};
        end else if (kind < 10) begin
            f3 = keptF3[2'(randBits(2))];
            return {12'(randBits(12)), rs1, f3, rd, 7'b0010011};
        end else if (kind < 14) begin
            sel = 3'(randBits(3) % 5);
            if (sel == 4) begin
                return {7'b0100000, rs2, rs1, 3'd0, rd, 7'b0110011};
            end
            return {7'b0, rs2, rs1, keptF3[sel[1:0]], rd, 7'b0110011};
        end else if (kind == 14) begin
            f3 = dropF3[2'(randBits(2))];
            if (randBits(1)) begin
                return {7'b0, rs2, rs1, f3, rd, 7'b0010011};
            end
            return {7'b0, rs2, rs1, f3, rd, 7'b0110011};
        end
        return {25'(randBits(25)), 7'b1100011};
    endfunction

    // Reference execution, queues every bus access the instruction makes
    task automatic modelInsn(input logic [31:0] insn, input logic [15:0] pc);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
        logic keptImm;
        logic keptOp;
        logic [31:0] res;
        f3 = insn[14:12];
        f7 = insn[31:25];
        rd = insn[10:7];
        rs1 = insn[18:15];
        rs2 = insn[23:20];
        keptImm = f3 == 0 || f3 == 4 || f3 == 6 || f3 == 7;
        keptOp = (f7 == 7'h00 && keptImm) || (f7 == 7'h20 && f3 == 0);
        for (int k = 0; k < 4; k++) begin
            expQ.push_back({1'b0, pc + 16'(k), 8'h00});
        end
        if (insn[6:0] == 7'b0110111) begin
            res = {insn[31:12], 12'h000};
            nLui++;
        end else if (insn[6:0] == 7'b0010011 && keptImm) begin
            expectWord(1'b0, rs1, 32'h0);
            res = aluRef(f3, 1'b0, regs[rs1], {{20{insn[31]}}, insn[31:20]});
            nImm++;
        end else if (insn[6:0] == 7'b0110011 && keptOp) begin
            // rs2 is read first, then rs1
            expectWord(1'b0, rs2, 32'h0);
            expectWord(1'b0, rs1, 32'h0);
            res = aluRef(f3, f7[5], regs[rs1], regs[rs2]);
            nOp++;
        end else begin
            nNop++;
            return;
        end
        regs[rd] = res;
        expectWord(1'b1, rd, res);
    endtask

    // Memory with 0 to 3 wait cycles, ready for one cycle
    always @(posedge cpuSignals) begin
        if (!arstN) begin
            ready <= 1'b0;
            busy <= 1'b0;
        end else if (ready) begin
            ready <= 1'b0;
            busy <= 1'b0;
        end else if (strobe) begin
            if (!busy) begin
                waitNow = int'(randBits(2));
                busy <= 1'b1;
            end else begin
                waitNow = int'(waitLeft);
            end
            if (waitNow == 0) begin
                ready <= 1'b1;
                dataRead <= mem[address];
                if (writeEnable) begin
                    mem[address] <= dataWrite;
                end
            end else begin
                waitLeft <= 2'(waitNow - 1);
            end
        end
    end

    // Each completed access against the next predicted one
    always @(posedge cpuSignals) begin
        if (arstN && strobe && ready) begin
            checks++;
            assert (expQ.size() != 0) else begin
                $display("Bus access at %0t with no access left in the model", $time);
                errors++;
            end
            if (expQ.size() != 0) begin
                expNow = expQ.pop_front();
                assert (writeEnable == expNow[24]) else begin
                    $display("MISMATCH %0t writeEnable got %b expected %b",
                             $time, writeEnable, expNow[24]);
                    errors++;
                end
                assert (address == expNow[23:8]) else begin
                    $display("MISMATCH %0t address got %h expected %h",
                             $time, address, expNow[23:8]);
                    errors++;
                end
                assert (!expNow[24] || dataWrite == expNow[7:0]) else begin
                    $display("MISMATCH %0t dataWrite got %h expected %h",
                             $time, dataWrite, expNow[7:0]);
                    errors++;
                end
            end
        end
    end

    always @(posedge cpuSignals) begin
        cycles++;
        if (cycles >= timeoutCycles) begin
            $display("Timeout after %0d cycles, %0d accesses never came", cycles, expQ.size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] insn;
        arstN = 1'b0;
        ready = 1'b0;
        dataRead = 8'h00;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = 8'h00;
        end
        // Random register contents, mirrored in the model
        for (int r = 0; r < 16; r++) begin
            regs[r] = randBits(32);
            for (int k = 0; k < 4; k++) begin
                mem[r * 4 + k] = regs[r][8*k +: 8];
            end
        end
        for (int i = 0; i < numInsns; i++) begin
            insn = makeInsn();
            for (int k = 0; k < 4; k++) begin
                mem[progBase + 16'(i * 4 + k)] = insn[8*k +: 8];
            end
            modelInsn(insn, progBase + 16'(i * 4));
        end

        // Reset over five edges, bus idle from the first reset edge
        // Last sample covers the first cycle after release
        for (int c = 0; c < 6; c++) begin
            @(posedge cpuSignals);
            if (c == 4) begin
                arstN <= 1'b1;
            end
            if (c > 0) begin
                checks++;
                assert (!strobe && !writeEnable) else begin
                    $display("Bus request active during or right after reset at %0t", $time);
                    errors++;
                end
            end
        end
        $display("Test reset done: %0d errors so far", errors);

        while (expQ.size() != 0) begin
            @(posedge cpuSignals);
        end
        $display("Test random program done: %0d LUI, %0d OP-IMM, %0d OP, %0d no-op",
                 nLui, nImm, nOp, nNop);
        $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/coreCfgPkg.sv ====
`default_nettype none

package coreCfgPkg;

    // Control FSM states
    typedef enum logic [2:0] {
        // Reading the four instruction bytes
        insnFetch,
        // Instruction word complete, pick the path
        insnDecode,
        // Reading rs2 into Y
        regFetchY,
        // Reading rs1 through the serial ALU into X
        regFetchX,
        // Writing X to rd, low byte first
        regStore
    } ctrlStateT;

    // Sixteen general registers kept in RAM
    localparam int regIdxWidth = 4;

    // Byte and word geometry of the register area
    localparam int byteBits = 8;
    localparam int wordBytes = 4;

endpackage

`default_nettype wire

// ==== verilog/coreControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module coreControl #(
    parameter int addrWidth = 16,
    parameter logic [addrWidth-1:0] resetPc = 'h2000
) (
    input  logic                                cpuSignals,
    input  logic                                arstN,
    output logic [addrWidth-1:0]                address,
    output logic                                writeEnable,
    output logic                                strobe,
    input  logic                                ready,
    input  logic                                isLui,
    input  logic                                isAluOp,
    input  logic                                isAluImm,
    input  riscvIsaPkg::aluOpT                  aluOpIn,
    input  logic [coreCfgPkg::regIdxWidth-1:0]  rs1Idx,
    input  logic [coreCfgPkg::regIdxWidth-1:0]  rs2Idx,
    input  logic [coreCfgPkg::regIdxWidth-1:0]  rdIdx,
    output logic                                bufLoad,
    output logic                                loadImmY,
    output logic                                loadImmX,
    output logic                                loadByteX,
    output logic                                shiftGo,
    output logic                                xFromAlu,
    output logic                                yFromX,
    output logic                                clearCarry,
    output riscvIsaPkg::aluOpT                  aluOp,
    input  logic                                shiftBusy
);

    coreCfgPkg::ctrlStateT state;
    logic [addrWidth-1:0] pc;
    // Byte within the current word, fetch or register
    logic [1:0] byteCnt;

    logic accessDone;
    logic byteIdle;
    logic lastInsnByte;
    logic lastWordByte;
    logic regRead;

    // Register n sits at byte address n * wordBytes
    function automatic logic [addrWidth-1:0] regAddr(
        input logic [coreCfgPkg::regIdxWidth-1:0] idx
    );
        return addrWidth'(idx) << $clog2(coreCfgPkg::wordBytes);
    endfunction

    assign accessDone = strobe && ready;
    // No access pending and the previous byte shift has finished
    assign byteIdle = !strobe && !shiftBusy;
    assign lastInsnByte = byteCnt == 2'(riscvIsaPkg::insnBytes - 1);
    assign lastWordByte = byteCnt == 2'(coreCfgPkg::wordBytes - 1);
    assign regRead = state == coreCfgPkg::regFetchY || state == coreCfgPkg::regFetchX;

    // Instruction byte lands in the buffer on the ready edge
    assign bufLoad = state == coreCfgPkg::insnFetch && accessDone;

    assign loadImmX = state == coreCfgPkg::insnDecode && isLui;
    assign loadImmY = state == coreCfgPkg::insnDecode && isAluOp && isAluImm;

    // Register byte goes into X[7:0], then an 8-bit shift
    assign loadByteX = regRead && accessDone;
    // Stores shift between bytes, but not after the last one
    assign shiftGo = loadByteX || (state == coreCfgPkg::regStore && accessDone && !lastWordByte);

    assign xFromAlu = state == coreCfgPkg::regFetchX;
    assign yFromX = state == coreCfgPkg::regFetchY;

    // Preset the carry right before the rs1 pass
    assign clearCarry = loadImmY ||
        (state == coreCfgPkg::regFetchY && byteIdle && lastWordByte);

    // Idle ALU adds, so nothing depends on a stale decode
    assign aluOp = isAluOp ? aluOpIn : riscvIsaPkg::aluAdd;

    always_ff @(posedge cpuSignals or negedge arstN) begin
        if (!arstN) begin
            state <= coreCfgPkg::insnFetch;
            pc <= resetPc;
            address <= '0;
            strobe <= 1'b0;
            writeEnable <= 1'b0;
            byteCnt <= '0;
        end else begin
            case (state)
                coreCfgPkg::insnFetch: begin
                    if (!strobe) begin
                        // Next instruction byte at the program counter
                        address <= pc;
                        strobe <= 1'b1;
                    end else if (ready) begin
                        strobe <= 1'b0;
                        pc <= pc + addrWidth'(1);
                        byteCnt <= byteCnt + 2'd1;
                        if (lastInsnByte) begin
                            state <= coreCfgPkg::insnDecode;
                        end
                    end
                end

                coreCfgPkg::insnDecode: begin
                    byteCnt <= '0;
                    if (isLui) begin
                        // X already holds the result, go straight to the store
                        address <= regAddr(rdIdx);
                        writeEnable <= 1'b1;
                        strobe <= 1'b1;
                        state <= coreCfgPkg::regStore;
                    end else if (isAluOp && isAluImm) begin
                        address <= regAddr(rs1Idx);
                        strobe <= 1'b1;
                        state <= coreCfgPkg::regFetchX;
                    end else if (isAluOp) begin
                        // rs2 first, it passes through X into Y
                        address <= regAddr(rs2Idx);
                        strobe <= 1'b1;
                        state <= coreCfgPkg::regFetchY;
                    end else begin
                        // Unsupported, PC already points past it
                        state <= coreCfgPkg::insnFetch;
                    end
                end

                coreCfgPkg::regFetchY, coreCfgPkg::regFetchX: begin
                    if (accessDone) begin
                        strobe <= 1'b0;
                    end else if (byteIdle) begin
                        strobe <= 1'b1;
                        if (!lastWordByte) begin
                            byteCnt <= byteCnt + 2'd1;
                            address <= address + addrWidth'(1);
                        end else if (state == coreCfgPkg::regFetchY) begin
                            // Y holds rs2, now stream rs1 through the ALU
                            byteCnt <= '0;
                            address <= regAddr(rs1Idx);
                            state <= coreCfgPkg::regFetchX;
                        end else begin
                            // Result complete in X
                            byteCnt <= '0;
                            address <= regAddr(rdIdx);
                            writeEnable <= 1'b1;
                            state <= coreCfgPkg::regStore;
                        end
                    end
                end

                coreCfgPkg::regStore: begin
                    if (accessDone) begin
                        strobe <= 1'b0;
                        if (lastWordByte) begin
                            writeEnable <= 1'b0;
                            byteCnt <= '0;
                            state <= coreCfgPkg::insnFetch;
                        end
                    end else if (byteIdle) begin
                        // Next byte rotated down into X[7:0]
                        byteCnt <= byteCnt + 2'd1;
                        address <= address + addrWidth'(1);
                        strobe <= 1'b1;
                    end
                end

                default: begin
                    state <= coreCfgPkg::insnFetch;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/insnDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module insnDecoder (
    input  logic [riscvIsaPkg::insnWidth-1:0]  insn,
    output logic                               isLui,
    output logic                               isAluOp,
    output logic                               isAluImm,
    output riscvIsaPkg::aluOpT                 aluOp,
    output logic [coreCfgPkg::regIdxWidth-1:0] rs1Idx,
    output logic [coreCfgPkg::regIdxWidth-1:0] rs2Idx,
    output logic [coreCfgPkg::regIdxWidth-1:0] rdIdx,
    output logic [31:0]                        immediate
);

    logic [6:0] opcode;
    logic isOp;
    logic isOpImm;
    logic [3:0] opCode;
    logic funcKept;
    logic funct7Ok;

    assign opcode = insn[6:0];
    assign isLui = opcode == riscvIsaPkg::opcodeLui;
    assign isOp = opcode == riscvIsaPkg::opcodeOp;
    assign isOpImm = opcode == riscvIsaPkg::opcodeOpImm;
    assign isAluImm = isOpImm;

    // Only the low four index bits, sixteen registers
    assign rs1Idx = insn[15 +: coreCfgPkg::regIdxWidth];
    assign rs2Idx = insn[20 +: coreCfgPkg::regIdxWidth];
    assign rdIdx = insn[7 +: coreCfgPkg::regIdxWidth];

    // Bit 30 is immediate data in OP-IMM, so it only selects SUB for OP
    assign opCode = {isOp && insn[30], insn[14:12]};

    always_comb begin
        case (opCode)
            riscvIsaPkg::aluAdd, riscvIsaPkg::aluSub, riscvIsaPkg::aluXor,
            riscvIsaPkg::aluOr, riscvIsaPkg::aluAnd: funcKept = 1'b1;
            default: funcKept = 1'b0;
        endcase
    end

    // Register form needs funct7 of 0000000 or 0100000, anything else is a no-op
    assign funct7Ok = !insn[31] && insn[29:25] == 5'b00000;

    assign isAluOp = funcKept && (isOpImm || (isOp && funct7Ok));
    assign aluOp = riscvIsaPkg::aluOpT'(opCode);

    // U-type for LUI, sign-extended I-type otherwise
    assign immediate = isLui ? {insn[31:12], 12'b0} : {{20{insn[31]}}, insn[31:20]};

endmodule

`default_nettype wire

// ==== verilog/insnFetchBuffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module insnFetchBuffer (
    input  logic                              cpuSignals,
    input  logic                              arstN,
    input  logic                              bufLoad,
    input  logic [7:0]                        dataRead,
    output logic [riscvIsaPkg::insnWidth-1:0] insn
);

    localparam int byteBits = coreCfgPkg::byteBits;

    // New byte enters at the top and older bytes move down
    // Four loads leave the first fetched byte in insn[7:0]
    always_ff @(posedge cpuSignals or negedge arstN) begin
        if (!arstN) begin
            insn <= '0;
        end else if (bufLoad) begin
            insn <= {dataRead, insn[riscvIsaPkg::insnWidth-1:byteBits]};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/riscvCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module riscvCore #(
    parameter int addrWidth = 16,
    parameter logic [addrWidth-1:0] resetPc = 'h2000
) (
    input  logic                 cpuSignals,
    input  logic                 arstN,
    output logic [addrWidth-1:0] address,
    output logic [7:0]           dataWrite,
    input  logic [7:0]           dataRead,
    output logic                 writeEnable,
    output logic                 strobe,
    input  logic                 ready
);

    // Fetch buffer to decoder
    logic [riscvIsaPkg::insnWidth-1:0] insn;
    logic bufLoad;

    // Decoded fields
    logic isLui;
    logic isAluOp;
    logic isAluImm;
    riscvIsaPkg::aluOpT decodedAluOp;
    logic [coreCfgPkg::regIdxWidth-1:0] rs1Idx;
    logic [coreCfgPkg::regIdxWidth-1:0] rs2Idx;
    logic [coreCfgPkg::regIdxWidth-1:0] rdIdx;
    logic [31:0] immediate;

    // Datapath controls
    logic loadImmX;
    logic loadImmY;
    logic loadByteX;
    logic shiftGo;
    logic xFromAlu;
    logic yFromX;
    logic clearCarry;
    logic shiftBusy;
    riscvIsaPkg::aluOpT aluOp;
    logic [7:0] xLowByte;

    coreControl #(
        .addrWidth(addrWidth),
        .resetPc(resetPc)
    ) uControl (
        .cpuSignals(cpuSignals),
        .arstN(arstN),
        .address(address),
        .writeEnable(writeEnable),
        .strobe(strobe),
        .ready(ready),
        .isLui(isLui),
        .isAluOp(isAluOp),
        .isAluImm(isAluImm),
        .aluOpIn(decodedAluOp),
        .rs1Idx(rs1Idx),
        .rs2Idx(rs2Idx),
        .rdIdx(rdIdx),
        .bufLoad(bufLoad),
        .loadImmY(loadImmY),
        .loadImmX(loadImmX),
        .loadByteX(loadByteX),
        .shiftGo(shiftGo),
        .xFromAlu(xFromAlu),
        .yFromX(yFromX),
        .clearCarry(clearCarry),
        .aluOp(aluOp),
        .shiftBusy(shiftBusy)
    );

    insnFetchBuffer uFetchBuffer (
        .cpuSignals(cpuSignals),
        .arstN(arstN),
        .bufLoad(bufLoad),
        .dataRead(dataRead),
        .insn(insn)
    );

    insnDecoder uDecoder (
        .insn(insn),
        .isLui(isLui),
        .isAluOp(isAluOp),
        .isAluImm(isAluImm),
        .aluOp(decodedAluOp),
        .rs1Idx(rs1Idx),
        .rs2Idx(rs2Idx),
        .rdIdx(rdIdx),
        .immediate(immediate)
    );

    serialDatapath uDatapath (
        .cpuSignals(cpuSignals),
        .arstN(arstN),
        .immediate(immediate),
        .dataRead(dataRead),
        .loadImmX(loadImmX),
        .loadImmY(loadImmY),
        .loadByteX(loadByteX),
        .shiftGo(shiftGo),
        .xFromAlu(xFromAlu),
        .yFromX(yFromX),
        .clearCarry(clearCarry),
        .aluOp(aluOp),
        .shiftBusy(shiftBusy),
        .xLowByte(xLowByte)
    );

    // Register stores always take the low byte of X
    assign dataWrite = xLowByte;

endmodule

`default_nettype wire

// ==== verilog/riscvIsaPkg.sv ====
`default_nettype none

package riscvIsaPkg;

    // Instruction word geometry
    localparam int insnWidth = 32;
    localparam int insnBytes = 4;

    // Major opcodes of the kept instructions, bits [6:0]
    localparam logic [6:0] opcodeLui = 7'b0110111;
    localparam logic [6:0] opcodeOp = 7'b0110011;
    localparam logic [6:0] opcodeOpImm = 7'b0010011;

    // ALU operation, coded as {funct7 bit 30, funct3}
    // Only the functions the core executes are listed
    typedef enum logic [3:0] {
        // Add, also used as the idle operation
        aluAdd = 4'b0000,
        // Subtract, register-register form only
        aluSub = 4'b1000,
        aluXor = 4'b0100,
        aluOr = 4'b0110,
        aluAnd = 4'b0111
    } aluOpT;

endpackage

`default_nettype wire

// ==== verilog/serialDatapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module serialDatapath (
    input  logic               cpuSignals,
    input  logic               arstN,
    input  logic [31:0]        immediate,
    input  logic [7:0]         dataRead,
    input  logic               loadImmX,
    input  logic               loadImmY,
    input  logic               loadByteX,
    input  logic               shiftGo,
    input  logic               xFromAlu,
    input  logic               yFromX,
    input  logic               clearCarry,
    input  riscvIsaPkg::aluOpT aluOp,
    output logic               shiftBusy,
    output logic [7:0]         xLowByte
);

    localparam int byteBits = coreCfgPkg::byteBits;
    localparam int wordBits = coreCfgPkg::wordBytes * byteBits;
    localparam int cntBits = $clog2(byteBits);

    logic [wordBits-1:0] x;
    logic [wordBits-1:0] y;
    logic carry;
    logic [cntBits-1:0] bitCnt;

    logic yBit;
    logic aluBit;
    logic carryOut;

    // Subtract is x + ~y + 1, the +1 comes from the preset carry
    assign yBit = (aluOp == riscvIsaPkg::aluSub) ? ~y[0] : y[0];

    always_comb begin
        case (aluOp)
            riscvIsaPkg::aluAdd, riscvIsaPkg::aluSub: begin
                aluBit = x[0] ^ yBit ^ carry;
                carryOut = (x[0] & yBit) | (x[0] & carry) | (yBit & carry);
            end
            riscvIsaPkg::aluAnd: begin
                aluBit = x[0] & y[0];
                carryOut = 1'b0;
            end
            riscvIsaPkg::aluOr: begin
                aluBit = x[0] | y[0];
                carryOut = 1'b0;
            end
            riscvIsaPkg::aluXor: begin
                aluBit = x[0] ^ y[0];
                carryOut = 1'b0;
            end
            default: begin
                aluBit = 1'b0;
                carryOut = 1'b0;
            end
        endcase
    end

    // Byte shift sequencing, 8 busy cycles after each shiftGo
    always_ff @(posedge cpuSignals or negedge arstN) begin
        if (!arstN) begin
            shiftBusy <= 1'b0;
            bitCnt <= '0;
            carry <= 1'b0;
        end else begin
            if (shiftGo) begin
                shiftBusy <= 1'b1;
                bitCnt <= '0;
            end else if (shiftBusy) begin
                bitCnt <= bitCnt + cntBits'(1);
                if (bitCnt == cntBits'(byteBits - 1)) begin
                    shiftBusy <= 1'b0;
                end
            end
            if (clearCarry) begin
                carry <= aluOp == riscvIsaPkg::aluSub;
            end else if (shiftBusy && xFromAlu) begin
                carry <= carryOut;
            end
        end
    end

    // Operand registers, LSB leaves first on every shift
    always_ff @(posedge cpuSignals) begin
        if (loadImmX) begin
            x <= immediate;
        end else if (loadByteX) begin
            x[byteBits-1:0] <= dataRead;
        end else if (shiftBusy) begin
            // ALU result when computing, plain rotate otherwise
            x <= {xFromAlu ? aluBit : x[0], x[wordBits-1:1]};
        end

        if (loadImmY) begin
            y <= immediate;
        end else if (shiftBusy) begin
            y <= {yFromX ? x[0] : y[0], y[wordBits-1:1]};
        end
    end

    assign xLowByte = x[byteBits-1:0];

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/riscvIsaPkg.sv
verilog/coreCfgPkg.sv
verilog/insnFetchBuffer.sv
verilog/insnDecoder.sv
verilog/serialDatapath.sv
verilog/coreControl.sv
verilog/riscvCore.sv
verif/riscvCore_sva.sv
verif/tbRiscvCore.sv
